/* rtl/bp_pkg.sv */
//------------------------------------------------
// gshare predictor widths, counter states, stage structs
// and the shared table index function
//------------------------------------------------
`default_nettype none

package bp_pkg;

	localparam int BHR_BITS = 6;
	localparam int NUM_PATTERNS = 64;
	localparam int PHT_IDX_BITS = $clog2(NUM_PATTERNS);
	localparam int PC_BITS = 64;

	typedef logic [PC_BITS-1:0] pc_t;
	// newest outcome sits in bit 0
	typedef logic [BHR_BITS-1:0] bhr_t;
	typedef logic [PHT_IDX_BITS-1:0] pht_idx_t;

	// bit 1 is the predicted direction
	typedef enum logic [1:0] {
		ST_NOT_TAKEN = 2'd0,
		WK_NOT_TAKEN = 2'd1,
		WK_TAKEN = 2'd2,
		ST_TAKEN = 2'd3
	} counter_t;

	typedef struct packed {
		logic valid;
		pc_t pc;
		logic cond0;
		logic cond1;
	} fetch_bundle_t;

	// one retired branch as reported by the ROB
	typedef struct packed {
		logic cond;
		pc_t pc;
		bhr_t bhr;
		logic taken;
	} retire_report_t;

	typedef struct packed {
		logic cond;
		pht_idx_t idx;
		logic taken;
	} pht_update_t;

	typedef struct packed {
		pht_update_t upd0;
		pht_update_t upd1;
		logic same_entry;
	} pht_update_pair_t;

	// bhr0 and bhr1 travel with the branches to the ROB
	typedef struct packed {
		logic valid;
		pc_t pc;
		logic taken0;
		logic taken1;
		bhr_t bhr0;
		bhr_t bhr1;
		logic slot1_live;
	} pred_result_t;

	// gshare index, word address bits xor history
	function automatic pht_idx_t pht_index(input pc_t pc, input bhr_t bhr);
		return pc[PHT_IDX_BITS+1:2] ^ bhr;
	endfunction

endpackage

`default_nettype wire

/* rtl/gshare_bht.sv */
//------------------------------------------------
// gshare history register and pattern table
// dual-slot prediction and counter training
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module gshare_bht import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input fetch_bundle_t fetch,
	input logic exception,
	input bhr_t exception_bhr,
	input pht_update_pair_t updates,
	output pred_result_t pred
);

	counter_t pht [NUM_PATTERNS];
	bhr_t bhr;
	bhr_t bhr_next;

	// prediction path
	bhr_t base_bhr;
	bhr_t inter_bhr;
	bhr_t slot1_bhr;
	pht_idx_t idx0;
	pht_idx_t idx1;
	pc_t pc1;
	logic br0;
	logic br1;
	logic taken0;
	logic taken1;

	// training path
	counter_t cnt0;
	counter_t cnt1;
	counter_t cnt_both;
	logic double_step;

	function automatic bhr_t shift_in(input bhr_t h, input logic outcome);
		return {h[BHR_BITS-2:0], outcome};
	endfunction

	// one saturating step toward the outcome
	function automatic counter_t step(input counter_t c, input logic taken);
		counter_t n;
		n = c;
		case (c)
			ST_NOT_TAKEN: n = taken ? WK_NOT_TAKEN : ST_NOT_TAKEN;
			WK_NOT_TAKEN: n = taken ? WK_TAKEN : ST_NOT_TAKEN;
			WK_TAKEN: n = taken ? ST_TAKEN : WK_NOT_TAKEN;
			ST_TAKEN: n = taken ? ST_TAKEN : WK_TAKEN;
			default: n = WK_NOT_TAKEN;
		endcase
		return n;
	endfunction

	// exception restores the history saved by the ROB
	assign base_bhr = exception ? exception_bhr : bhr;

	// conds only count for a valid bundle
	assign br0 = fetch.valid & fetch.cond0;
	assign br1 = fetch.valid & fetch.cond1;

	assign idx0 = pht_index(fetch.pc, base_bhr);
	assign taken0 = br0 & pht[idx0][1];

	// slot 0 falls through, so its not-taken bit is already in
	assign inter_bhr = br0 ? shift_in(base_bhr, 1'b0) : base_bhr;
	assign slot1_bhr = taken0 ? shift_in(base_bhr, 1'b1) : inter_bhr;

	assign pc1 = fetch.pc + pc_t'(4);
	assign idx1 = pht_index(pc1, inter_bhr);
	// a taken slot 0 redirects fetch, slot 1 is never looked up
	assign taken1 = br1 & ~taken0 & pht[idx1][1];

	// only a live slot-1 branch adds a second bit
	assign bhr_next = (br1 & ~taken0) ? shift_in(inter_bhr, taken1) : slot1_bhr;

	always_comb begin
		pred.valid = fetch.valid;
		pred.pc = fetch.pc;
		pred.taken0 = taken0;
		pred.taken1 = taken1;
		pred.bhr0 = base_bhr;
		pred.bhr1 = slot1_bhr;
		pred.slot1_live = fetch.valid & ~taken0;
	end

	// next counter values for the registered retire updates
	assign cnt0 = step(pht[updates.upd0.idx], updates.upd0.taken);
	assign cnt1 = step(pht[updates.upd1.idx], updates.upd1.taken);
	// slot 0 first, then slot 1 on the same entry
	assign cnt_both = step(cnt0, updates.upd1.taken);
	assign double_step = updates.same_entry & updates.upd0.cond & updates.upd1.cond;

	always_ff @(posedge clock) begin
		if (reset) begin
			bhr <= '0;
			for (int i = 0; i < NUM_PATTERNS; i++) begin
				pht[i] <= WK_NOT_TAKEN;
			end
		end else begin
			bhr <= bhr_next;
			if (double_step) begin
				pht[updates.upd0.idx] <= cnt_both;
			end else begin
				if (updates.upd0.cond) begin
					pht[updates.upd0.idx] <= cnt0;
				end
				if (updates.upd1.cond) begin
					pht[updates.upd1.idx] <= cnt1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/retire_update_stage.sv */
//------------------------------------------------
// retire stage, reports to registered table updates
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module retire_update_stage import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input retire_report_t retire0,
	input retire_report_t retire1,
	output pht_update_pair_t updates
);

	pht_idx_t idx0;
	pht_idx_t idx1;
	pht_update_pair_t updates_next;

	// same index the branch was predicted with
	assign idx0 = pht_index(retire0.pc, retire0.bhr);
	assign idx1 = pht_index(retire1.pc, retire1.bhr);

	always_comb begin
		updates_next.upd0.cond = retire0.cond;
		updates_next.upd0.idx = idx0;
		updates_next.upd0.taken = retire0.taken;
		updates_next.upd1.cond = retire1.cond;
		updates_next.upd1.idx = idx1;
		updates_next.upd1.taken = retire1.taken;
		// two retires hitting one counter need a double step
		updates_next.same_entry = retire0.cond & retire1.cond & (idx0 == idx1);
	end

	// registered updates, cond bits and same_entry clear on reset
	always_ff @(posedge clock) begin
		updates <= updates_next;
		if (reset) begin
			updates.upd0.cond <= 1'b0;
			updates.upd1.cond <= 1'b0;
			updates.same_entry <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/ifid_pred_reg.sv */
//------------------------------------------------
// fetch/decode register for predictions
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ifid_pred_reg import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input logic flush,
	input pred_result_t pred,
	output pred_result_t id_pred
);

	logic kill;

	assign kill = reset | flush;

	// histories are held here so decode can pass them to the ROB
	always_ff @(posedge clock) begin
		id_pred <= pred;
		if (kill) begin
			id_pred.valid <= 1'b0;
			id_pred.taken0 <= 1'b0;
			id_pred.taken1 <= 1'b0;
			id_pred.slot1_live <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* rtl/bp_frontend.sv */
//------------------------------------------------
// branch predictor top, predict, fetch/decode and retire
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bp_frontend import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input fetch_bundle_t fetch,
	input logic exception,
	input bhr_t exception_bhr,
	input retire_report_t retire0,
	input retire_report_t retire1,
	output pred_result_t id_pred
);

	pred_result_t pred;
	pht_update_pair_t updates;

	// predict stage, speculative history and table
	gshare_bht gshare_bht_inst (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.exception(exception),
		.exception_bhr(exception_bhr),
		.updates(updates),
		.pred(pred)
	);

	// exception also drops the bundle in flight
	ifid_pred_reg ifid_pred_reg_inst (
		.clock(clock),
		.reset(reset),
		.flush(exception),
		.pred(pred),
		.id_pred(id_pred)
	);

	retire_update_stage retire_update_stage_inst (
		.clock(clock),
		.reset(reset),
		.retire0(retire0),
		.retire1(retire1),
		.updates(updates)
	);

endmodule

`default_nettype wire

/* tests/bp_frontend_asserts.sv */
//------------------------------------------------
// concurrent checks on the predictor outputs
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bp_frontend_asserts import bp_pkg::*; (
	input logic clock,
	input logic reset,
	input logic exception,
	input pred_result_t id_pred
);

	// flushed bundle never reaches decode
	flush_clears_valid: assert property (
		@(posedge clock) disable iff (reset) exception |=> !id_pred.valid
	) else $error("id_pred valid one cycle after an exception");

	// taken slot 0 redirects, slot 1 is off the path
	taken0_kills_slot1: assert property (
		@(posedge clock) disable iff (reset) id_pred.taken0 |-> !id_pred.slot1_live
	) else $error("slot1_live high with slot 0 taken");

	taken1_needs_live: assert property (
		@(posedge clock) disable iff (reset) id_pred.taken1 |-> id_pred.slot1_live
	) else $error("taken1 high while slot 1 is not live");

endmodule

`default_nettype wire

/* tests/tb_bp_frontend.sv */
//------------------------------------------------
// testbench for the gshare front end
// step table, reference model and watchdog
//------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_bp_frontend import bp_pkg::*; ();

	typedef struct packed {
		fetch_bundle_t fetch;
		logic exception;
		bhr_t exception_bhr;
		retire_report_t retire0;
		retire_report_t retire1;
	} step_t;

	logic clock = 1'b0;
	logic reset;
	fetch_bundle_t fetch;
	logic exception;
	bhr_t exception_bhr;
	retire_report_t retire0;
	retire_report_t retire1;
	pred_result_t id_pred;

	step_t steps[$];
	logic table_built = 1'b0;

	// reference model state
	bhr_t model_bhr;
	logic [1:0] model_pht [NUM_PATTERNS];
	pht_update_t pend0;
	pht_update_t pend1;
	pred_result_t expected;

	// 8 ns period
	always #4 clock = ~clock;

	bp_frontend bp_frontend_inst (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.exception(exception),
		.exception_bhr(exception_bhr),
		.retire0(retire0),
		.retire1(retire1),
		.id_pred(id_pred)
	);

	bind bp_frontend bp_frontend_asserts bp_frontend_asserts_inst (
		.clock(clock),
		.reset(reset),
		.exception(exception),
		.id_pred(id_pred)
	);

	// word address bits 7:2 xor history
	function automatic pht_idx_t table_index(input pc_t pc, input bhr_t h);
		return pc[7:2] ^ h;
	endfunction

	function automatic fetch_bundle_t make_fetch(input logic valid, input pc_t pc,
			input logic cond0, input logic cond1);
		fetch_bundle_t f;
		f.valid = valid;
		f.pc = pc;
		f.cond0 = cond0;
		f.cond1 = cond1;
		return f;
	endfunction

	function automatic retire_report_t make_retire(input logic cond, input pc_t pc,
			input bhr_t h, input logic taken);
		retire_report_t r;
		r.cond = cond;
		r.pc = pc;
		r.bhr = h;
		r.taken = taken;
		return r;
	endfunction

	// bits 7:5 cleared so random traffic crowds a few entries
	function automatic pc_t random_pc();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $urandom();
		lo = $urandom();
		return {hi, lo[31:8], 3'b000, lo[4:2], 2'b00};
	endfunction

	task automatic add_step(input fetch_bundle_t f, input logic exc, input bhr_t eb,
			input retire_report_t r0, input retire_report_t r1);
		step_t s;
		s.fetch = f;
		s.exception = exc;
		s.exception_bhr = eb;
		s.retire0 = r0;
		s.retire1 = r1;
		steps.push_back(s);
	endtask

	task automatic fetch_only(input pc_t pc, input logic cond0, input logic cond1);
		add_step(make_fetch(1'b1, pc, cond0, cond1), 1'b0, '0, '0, '0);
	endtask

	// exception with no bundle, history only
	task automatic restore_history(input bhr_t h);
		add_step(make_fetch(1'b0, '0, 1'b0, 1'b0), 1'b1, h, '0, '0);
	endtask

	task automatic retire_only(input retire_report_t r0, input retire_report_t r1);
		add_step(make_fetch(1'b0, '0, 1'b0, 1'b0), 1'b0, '0, r0, r1);
	endtask

	task automatic build_table();
		retire_report_t hit_taken;
		retire_report_t hit_not_taken;
		retire_report_t r0;
		retire_report_t r1;
		fetch_bundle_t f;
		logic [31:0] rnd;
		// cold table, nothing taken
		fetch_only(64'h1000, 1'b1, 1'b1);
		fetch_only(64'h1008, 1'b1, 1'b0);
		fetch_only(64'h1010, 1'b0, 1'b1);
		fetch_only(64'h1018, 1'b0, 1'b0);
		// entry 0x10 under zero history
		hit_taken = make_retire(1'b1, 64'h2040, 6'h00, 1'b1);
		hit_not_taken = make_retire(1'b1, 64'h2040, 6'h00, 1'b0);
		retire_only(hit_taken, '0);
		retire_only(hit_taken, '0);
		retire_only('0, '0);
		fetch_only(64'h2040, 1'b1, 1'b1);
		// branch-free bundle shows one bit gained by the taken slot 0
		add_step(make_fetch(1'b1, 64'h1000, 1'b0, 1'b0), 1'b0, '0, hit_taken, '0);
		retire_only(hit_not_taken, '0);
		restore_history(6'h00);
		fetch_only(64'h2040, 1'b1, 1'b0);
		retire_only(hit_not_taken, '0);
		restore_history(6'h00);
		fetch_only(64'h2040, 1'b1, 1'b0);
		// slot 1 at 0x3004 looked up with intermediate history 0x06
		retire_only(make_retire(1'b1, 64'h3004, 6'h06, 1'b1), '0);
		retire_only(make_retire(1'b1, 64'h3004, 6'h06, 1'b1), '0);
		restore_history(6'h03);
		fetch_only(64'h3000, 1'b1, 1'b1);
		fetch_only(64'h3100, 1'b1, 1'b0);
		// exception on a live bundle, then continue from it
		add_step(make_fetch(1'b1, 64'h5000, 1'b1, 1'b0), 1'b1, 6'h2a, '0, '0);
		fetch_only(64'h5008, 1'b0, 1'b1);
		fetch_only(64'h5010, 1'b1, 1'b1);
		// double step on entry 0x3c
		retire_only(make_retire(1'b1, 64'h40f0, 6'h00, 1'b1),
			make_retire(1'b1, 64'h40f0, 6'h00, 1'b1));
		restore_history(6'h00);
		fetch_only(64'h40f0, 1'b1, 1'b0);
		retire_only(make_retire(1'b1, 64'h40f0, 6'h00, 1'b0), '0);
		restore_history(6'h00);
		fetch_only(64'h40f0, 1'b1, 1'b0);
		// mixed random traffic
		for (int n = 0; n < 40; n++) begin
			rnd = $urandom();
			f = make_fetch(rnd[0] | rnd[1], random_pc(), rnd[2], rnd[3]);
			r0 = make_retire(rnd[4] | rnd[5], random_pc(), {4'b0000, rnd[7:6]},
				rnd[8] | rnd[9]);
			r1 = make_retire(rnd[10] | rnd[11], random_pc(), {4'b0000, rnd[13:12]},
				rnd[14] | rnd[15]);
			add_step(f, rnd[19:16] == 4'h0, rnd[25:20], r0, r1);
		end
	endtask

	task automatic reset_model();
		model_bhr = '0;
		// weakly not taken
		for (int i = 0; i < NUM_PATTERNS; i++) begin
			model_pht[i] = 2'd1;
		end
		pend0 = '0;
		pend1 = '0;
		expected = '0;
	endtask

	function automatic pht_update_t to_update(input retire_report_t r);
		pht_update_t u;
		u.cond = r.cond;
		u.idx = table_index(r.pc, r.bhr);
		u.taken = r.taken;
		return u;
	endfunction

	// saturating step, applied in slot order
	task automatic train_counter(input pht_update_t u);
		if (u.cond) begin
			if (u.taken && model_pht[u.idx] != 2'd3) begin
				model_pht[u.idx] = model_pht[u.idx] + 2'd1;
			end else if (!u.taken && model_pht[u.idx] != 2'd0) begin
				model_pht[u.idx] = model_pht[u.idx] - 2'd1;
			end
		end
	endtask

	task automatic model_step(input step_t s);
		bhr_t base;
		bhr_t inter;
		bhr_t hist1;
		pht_idx_t i0;
		pht_idx_t i1;
		logic br0;
		logic br1;
		logic t0;
		logic t1;
		base = s.exception ? s.exception_bhr : model_bhr;
		br0 = s.fetch.valid & s.fetch.cond0;
		br1 = s.fetch.valid & s.fetch.cond1;
		i0 = table_index(s.fetch.pc, base);
		t0 = br0 & model_pht[i0][1];
		inter = br0 ? {base[BHR_BITS-2:0], 1'b0} : base;
		t1 = 1'b0;
		if (t0) begin
			hist1 = {base[BHR_BITS-2:0], 1'b1};
			model_bhr = hist1;
		end else begin
			hist1 = inter;
			i1 = table_index(s.fetch.pc + 64'd4, inter);
			t1 = br1 & model_pht[i1][1];
			model_bhr = br1 ? {inter[BHR_BITS-2:0], t1} : inter;
		end
		expected.valid = s.fetch.valid & ~s.exception;
		expected.pc = s.fetch.pc;
		expected.taken0 = expected.valid & t0;
		expected.taken1 = expected.valid & t1;
		expected.bhr0 = base;
		expected.bhr1 = hist1;
		expected.slot1_live = expected.valid & ~t0;
		// retire updates land one cycle after the report
		train_counter(pend0);
		train_counter(pend1);
		pend0 = to_update(s.retire0);
		pend1 = to_update(s.retire1);
	endtask

	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] want);
		if (actual !== want) begin
			$display("MISMATCH time=%0t %s actual=%0h expected=%0h",
				$time, name, actual, want);
			$display("TEST FAILED");
			$fatal(1, "%s differs from the reference model", name);
		end
	endtask

	// payload fields only mean something on a valid result
	task automatic compare_outputs();
		check_value("id_pred.valid", 64'(id_pred.valid), 64'(expected.valid));
		check_value("id_pred.taken0", 64'(id_pred.taken0), 64'(expected.taken0));
		check_value("id_pred.taken1", 64'(id_pred.taken1), 64'(expected.taken1));
		check_value("id_pred.slot1_live", 64'(id_pred.slot1_live),
			64'(expected.slot1_live));
		if (expected.valid) begin
			check_value("id_pred.pc", id_pred.pc, expected.pc);
			check_value("id_pred.bhr0", 64'(id_pred.bhr0), 64'(expected.bhr0));
			check_value("id_pred.bhr1", 64'(id_pred.bhr1), 64'(expected.bhr1));
		end
	endtask

	task automatic apply_step(input step_t s);
		fetch = s.fetch;
		exception = s.exception;
		exception_bhr = s.exception_bhr;
		retire0 = s.retire0;
		retire1 = s.retire1;
	endtask

	initial begin
		void'($urandom(12161));
		reset = 1'b1;
		fetch = '0;
		exception = 1'b0;
		exception_bhr = '0;
		retire0 = '0;
		retire1 = '0;
		reset_model();
		build_table();
		table_built = 1'b1;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		for (int k = 0; k < steps.size(); k++) begin
			@(negedge clock);
			compare_outputs();
			apply_step(steps[k]);
			model_step(steps[k]);
		end
		@(negedge clock);
		compare_outputs();
		apply_step('0);
		$display("TEST OK");
		$finish;
	end

	// four cycles per step plus the reset time
	initial begin
		int limit;
		wait (table_built);
		limit = steps.size() * 4 + 16;
		repeat (limit) @(posedge clock);
		$display("watchdog expired after %0d cycles before the step table finished", limit);
		$display("TEST FAILED");
		$fatal(1, "simulation timed out");
	end

endmodule

`default_nettype wire

/* build.f */
rtl/bp_pkg.sv
rtl/gshare_bht.sv
rtl/retire_update_stage.sv
rtl/ifid_pred_reg.sv
rtl/bp_frontend.sv
tests/bp_frontend_asserts.sv
tests/tb_bp_frontend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile the branch predictor testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

top=tb_bp_frontend

if ! verilator --binary --timing --assert --top-module "$top" -f build.f; then
	echo "verilator build failed"
	exit 1
fi

if ! sim_output=$("./obj_dir/V${top}" 2>&1); then
	echo "$sim_output"
	echo "simulation exited with an error status"
	exit 1
fi

echo "$sim_output"

if echo "$sim_output" | grep -q "^TEST OK$"; then
	exit 0
else
	echo "pass message not found in simulation output"
	exit 1
fi
